// File: common/frontend_pkg.sv
package frontend_pkg;

    // datapath and address width
    localparam int xlen = 32;

    // instruction queue sizing
    localparam int iq_depth = 32;
    localparam int iq_ptr_w = 5;

    // branch history table, indexed by pc[7:2]
    localparam int bht_entries = 64;
    localparam int bht_idx_w = 6;

    // rv32i major opcodes seen by the fetch unit
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // sequential fetch increment
    localparam logic [xlen-1:0] next_pc_step = 32'd4;

    // 2-bit saturating counter encodings
    // 00 strong not taken, 01 weak not taken, 10 weak taken, 11 strong taken
    localparam logic [1:0] ctr_init = 2'b01;
    localparam logic [1:0] ctr_min = 2'b00;
    localparam logic [1:0] ctr_max = 2'b11;

    // one queue slot
    typedef struct packed {
        logic [31:0] inst;
        logic [xlen-1:0] pc;
        logic pred;
    } fetch_entry_t;

endpackage

// File: common/iq_if.sv
`timescale 1ns/1ps

interface iq_if (
    input logic clk
);
    import frontend_pkg::*;

    logic push;
    fetch_entry_t push_entry;
    logic full;
    logic pop;
    fetch_entry_t pop_entry;
    logic empty;
    logic flush;

    // fetch side
    modport producer (
        input clk,
        output push,
        output push_entry,
        output flush,
        input full
    );

    // storage
    modport buffer (
        input clk,
        input push,
        input push_entry,
        input pop,
        input flush,
        output full,
        output empty,
        output pop_entry
    );

    // dispatch side
    modport consumer (
        input clk,
        output pop,
        input empty,
        input pop_entry
    );

endinterface

// File: fetch/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic clk,
    input  logic rst,
    input  logic [frontend_pkg::xlen-1:0] lookup_pc,
    output logic taken,
    input  logic upd_en,
    input  logic [frontend_pkg::xlen-1:0] upd_pc,
    input  logic upd_taken
);
    import frontend_pkg::*;

    logic [1:0] ctr [bht_entries];
    logic [bht_idx_w-1:0] lookup_idx;
    logic [bht_idx_w-1:0] upd_idx;
    logic [1:0] upd_cur;

    // word aligned, so the low two bits carry no information
    assign lookup_idx = lookup_pc[bht_idx_w+1:2];
    assign upd_idx = upd_pc[bht_idx_w+1:2];

    // msb of the counter is the prediction
    assign taken = ctr[lookup_idx][1];

    assign upd_cur = ctr[upd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bht_entries; i++) begin
                ctr[i] <= ctr_init;
            end
        end else if (upd_en) begin
            if (upd_taken) begin
                if (upd_cur != ctr_max) begin
                    ctr[upd_idx] <= upd_cur + 2'd1;
                end
            end else begin
                if (upd_cur != ctr_min) begin
                    ctr[upd_idx] <= upd_cur - 2'd1;
                end
            end
        end
    end

endmodule

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic clr,
    input  logic [frontend_pkg::xlen-1:0] j_pc,
    input  logic mc_wait,
    input  logic ic_done,
    input  logic [31:0] ic_inst,
    output logic ic_en,
    output logic [frontend_pkg::xlen-1:0] ic_pc,
    output logic [frontend_pkg::xlen-1:0] bp_pc,
    input  logic bp_taken,
    iq_if.producer q
);
    import frontend_pkg::*;

    logic [xlen-1:0] pc;
    logic outstanding;
    logic stale;
    logic req_start;
    logic reply;
    logic accept;
    logic is_jal;
    logic is_branch;
    logic take_branch;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] next_pc;

    // only one request in flight, and only with room left in the queue
    assign req_start = rdy && !clr && !outstanding && !mc_wait && !q.full;

    // reply to the request in flight; stale ones are dropped
    assign reply = ic_done && outstanding;
    assign accept = rdy && !clr && reply && !stale;

    assign is_jal = (ic_inst[6:0] == opc_jal);
    assign is_branch = (ic_inst[6:0] == opc_branch);
    assign take_branch = is_branch && bp_taken;

    assign imm_j = {{12{ic_inst[31]}}, ic_inst[19:12], ic_inst[20], ic_inst[30:21], 1'b0};
    assign imm_b = {{20{ic_inst[31]}}, ic_inst[7], ic_inst[30:25], ic_inst[11:8], 1'b0};

    always_comb begin
        if (is_jal) begin
            next_pc = pc + imm_j;
        end else if (take_branch) begin
            next_pc = pc + imm_b;
        end else begin
            next_pc = pc + next_pc_step;
        end
    end

    // predictor looks up the address of the request in flight
    assign bp_pc = pc;

    assign q.push = accept;
    assign q.push_entry = '{inst: ic_inst, pc: pc, pred: take_branch};
    assign q.flush = clr;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            outstanding <= 1'b0;
            stale <= 1'b0;
            ic_en <= 1'b0;
        end else if (clr) begin
            pc <= j_pc;
            ic_en <= 1'b0;
            // a reply still owed by the cache must be thrown away
            outstanding <= outstanding && !ic_done;
            stale <= outstanding && !ic_done;
        end else if (rdy) begin
            if (reply) begin
                outstanding <= 1'b0;
                stale <= 1'b0;
                ic_en <= 1'b0;
                if (!stale) begin
                    pc <= next_pc;
                end
            end else if (req_start) begin
                outstanding <= 1'b1;
                ic_en <= 1'b1;
            end
        end
    end

    // request address, held while ic_en is up
    always_ff @(posedge clk) begin
        if (req_start) begin
            ic_pc <= pc;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_frontend \
    -f sources.f \
    -o sim_frontend

out="$(./obj_dir/sim_frontend)" || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -Fqx "=== PASS ==="; then
    exit 0
fi
exit 1

// File: sim/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic pd;
    } dec_item_t;

    logic clk = 1'b0;
    logic rst, rdy, clr, mc_wait, ic_done;
    logic [31:0] j_pc, ic_inst, ic_pc;
    logic bp_upd_en, bp_upd_taken;
    logic [31:0] bp_upd_pc;
    logic rob_full, slb_full, rs_full;
    logic ic_en, dec_en, dec_pd;
    logic [31:0] dec_inst, dec_pc;

    integer seed = 32'h6f3f_6b57;
    int fixed_latency;
    logic [31:0] image [1024];
    // jump or branch offset each image word was built with
    logic [31:0] jump_off [1024];

    // reference model state, updated at the falling edge
    logic [31:0] ref_pc;
    logic ref_out, ref_stale, ic_en_last, rdy_last;
    logic [1:0] bht_model [64];
    dec_item_t exp_q [$];
    dec_item_t head, item;
    int dec_count, req_count, seen_jal, seen_taken, seen_fall;

    frontend_top u_frontend_top (.*);

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check_failed(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
        abort_run();
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] encode_jal(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic logic [31:0] encode_beq(input logic [31:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic place_jal(input logic [31:0] addr, input logic [31:0] off);
        image[addr[11:2]] = encode_jal(off);
        jump_off[addr[11:2]] = off;
    endtask

    task automatic place_beq(input logic [31:0] addr, input logic [31:0] off);
        image[addr[11:2]] = encode_beq(off);
        jump_off[addr[11:2]] = off;
    endtask

    // cache serves every rising ic_en, even one that a flush turns stale
    initial begin
        logic [31:0] addr;
        int lat;
        ic_done = 1'b0;
        ic_inst = '0;
        forever begin
            next_cycle();
            if (ic_en === 1'b1 && !rst) begin
                addr = ic_pc;
                lat = 1 + int'($unsigned($random(seed)) % 32'd4);
                if (fixed_latency > 0) begin
                    lat = fixed_latency;
                end
                for (int i = 1; i < lat; i++) begin
                    next_cycle();
                end
                ic_done = 1'b1;
                ic_inst = image[addr[11:2]];
                next_cycle();
                ic_done = 1'b0;
                ic_inst = '0;
            end
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            ref_pc = '0;
            ref_out = 1'b0;
            ref_stale = 1'b0;
            ic_en_last = 1'b0;
            rdy_last = 1'b1;
            exp_q.delete();
            for (int i = 0; i < 64; i++) begin
                bht_model[i] = 2'b01;
            end
        end else begin
            // a held dec_en under a frozen front end is not a new instruction
            if (dec_en && rdy_last) begin
                assert (exp_q.size() > 0)
                    else check_failed("dec_en pulsed with no instruction expected");
                head = exp_q.pop_front();
                assert (dec_pc == head.pc) else value_mismatch("dec_pc", dec_pc, head.pc);
                assert (dec_inst == head.inst)
                    else value_mismatch("dec_inst", dec_inst, head.inst);
                assert (dec_pd == head.pd)
                    else value_mismatch("dec_pd", {31'd0, dec_pd}, {31'd0, head.pd});
                dec_count++;
                if (head.inst[6:0] == 7'b1101111) seen_jal++;
                if (head.inst[6:0] == 7'b1100011 && head.pd) seen_taken++;
                if (head.inst[6:0] == 7'b1100011 && !head.pd) seen_fall++;
            end else if (!dec_en) begin
                assert (dec_inst == 32'd0 && dec_pc == 32'd0 && !dec_pd)
                    else check_failed("decoder outputs not cleared while dispatch is idle");
            end
            if (ic_en && !ic_en_last) begin
                assert (!ref_out) else check_failed("a second request started too early");
                assert (ic_pc == ref_pc) else value_mismatch("ic_pc", ic_pc, ref_pc);
                assert (exp_q.size() < 32) else check_failed("a request started while full");
                ref_out = 1'b1;
                req_count++;
            end
            if (clr) begin
                exp_q.delete();
                ref_pc = j_pc;
                ref_stale = ref_out && !ic_done;
                ref_out = ref_out && !ic_done;
            end else if (rdy && ic_done && ref_out) begin
                if (!ref_stale) begin
                    item.inst = image[ref_pc[11:2]];
                    item.pc = ref_pc;
                    item.pd = (item.inst[6:0] == 7'b1100011) && bht_model[ref_pc[7:2]][1];
                    exp_q.push_back(item);
                    if (item.inst[6:0] == 7'b1101111 || item.pd) begin
                        ref_pc = ref_pc + jump_off[ref_pc[11:2]];
                    end else begin
                        ref_pc = ref_pc + 32'd4;
                    end
                end
                ref_out = 1'b0;
                ref_stale = 1'b0;
            end
            // saturating 2-bit counters
            if (bp_upd_en && bp_upd_taken && bht_model[bp_upd_pc[7:2]] != 2'b11) begin
                bht_model[bp_upd_pc[7:2]] = bht_model[bp_upd_pc[7:2]] + 2'd1;
            end else if (bp_upd_en && !bp_upd_taken && bht_model[bp_upd_pc[7:2]] != 2'b00) begin
                bht_model[bp_upd_pc[7:2]] = bht_model[bp_upd_pc[7:2]] - 2'd1;
            end
            ic_en_last = ic_en;
            rdy_last = rdy;
        end
    end

    a_clr_dec: assert property (@(posedge clk) disable iff (rst) clr |=> !dec_en)
        else check_failed("dec_en high in the cycle after clr");
    a_clr_ic: assert property (@(posedge clk) disable iff (rst) clr |=> !ic_en)
        else check_failed("ic_en high in the cycle after clr");
    a_stall: assert property (@(posedge clk) disable iff (rst)
        (rdy && (rob_full || slb_full || rs_full)) |=> !dec_en)
        else check_failed("dec_en rose while the back end was full");
    a_frozen: assert property (@(posedge clk) disable iff (rst) (!rdy && !dec_en) |=> !dec_en)
        else check_failed("dec_en rose while rdy was low");
    a_no_req: assert property (@(posedge clk) disable iff (rst)
        (!ic_en && (!rdy || mc_wait)) |=> !ic_en)
        else check_failed("a request started under mc_wait or with rdy low");
    a_ic_hold: assert property (@(posedge clk) disable iff (rst)
        (ic_en && !ic_done && !clr) |=> ic_en)
        else check_failed("ic_en dropped before the cache answered");
    a_ic_drop: assert property (@(posedge clk) disable iff (rst) (rdy && ic_done) |=> !ic_en)
        else check_failed("ic_en still high after ic_done");

    task automatic wait_dispatched(input int target, input int limit);
        int n;
        n = 0;
        while (dec_count < target) begin
            next_cycle();
            n++;
            if (n > limit) check_failed("timed out waiting for instructions to dispatch");
        end
    endtask

    task automatic wait_request(input int start, input int limit);
        int n;
        n = 0;
        while (req_count <= start) begin
            next_cycle();
            n++;
            if (n > limit) check_failed("timed out waiting for a cache request");
        end
    endtask

    task automatic wait_queue_level(input int level, input int limit);
        int n;
        n = 0;
        while (exp_q.size() != level) begin
            next_cycle();
            n++;
            if (n > limit) check_failed("timed out waiting for the queue to fill");
        end
    endtask

    task automatic wait_fetch_idle(input int limit);
        int n;
        n = 0;
        while (ic_en) begin
            next_cycle();
            n++;
            if (n > limit) check_failed("timed out waiting for the cache request to finish");
        end
    endtask

    task automatic expect_quiet(input int cycles, input bit dec_too);
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            assert (!ic_en) else check_failed("ic_en rose while requests were blocked");
            assert (!dec_too || !dec_en) else check_failed("dec_en rose while blocked");
        end
    endtask

    initial begin
        #40000;
        check_failed("simulation watchdog expired");
    end

    initial begin
        int start;
        {rst, rdy, clr, mc_wait, bp_upd_en, bp_upd_taken} = 6'b110000;
        {rob_full, slb_full, rs_full} = 3'b000;
        j_pc = '0;
        bp_upd_pc = '0;
        fixed_latency = 0;
        for (int a = 0; a < 1024; a++) begin
            image[a] = {a[9:0], 2'b00, 5'd0, 3'b000, 5'd1, 7'b0010011};
            jump_off[a] = '0;
        end
        place_jal(32'h040, 32'h0000_00c0);
        place_beq(32'h110, 32'h0000_0040);
        place_beq(32'h120, 32'h0000_0060);
        place_jal(32'h1c0, 32'hffff_fe40);
        place_jal(32'h340, 32'hffff_fcc0);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!ic_en) else value_mismatch("ic_en", {31'd0, ic_en}, 32'd0);
        assert (!dec_en) else value_mismatch("dec_en", {31'd0, dec_en}, 32'd0);
        // one taken update moves the branch at 0x120 to weakly taken
        {bp_upd_en, bp_upd_taken, bp_upd_pc} = {2'b11, 32'h0000_0120};
        next_cycle();
        bp_upd_en = 1'b0;
        wait_dispatched(60, 1500);

        rob_full = 1'b1;
        wait_queue_level(32, 1500);
        expect_quiet(20, 1'b1);
        {rob_full, slb_full} = 2'b01;
        expect_quiet(10, 1'b1);
        {slb_full, rs_full} = 2'b01;
        expect_quiet(10, 1'b1);
        rs_full = 1'b0;
        wait_dispatched(dec_count + 40, 1500);

        fixed_latency = 4;
        next_cycle();
        start = req_count;
        wait_request(start, 100);
        {clr, j_pc} = {1'b1, 32'h0000_0300};
        next_cycle();
        {clr, j_pc} = {1'b0, 32'h0};
        assert (!dec_en) else value_mismatch("dec_en", {31'd0, dec_en}, 32'd0);
        fixed_latency = 0;
        start = req_count;
        wait_request(start, 100);
        assert (ic_pc == 32'h300) else value_mismatch("ic_pc", ic_pc, 32'h300);
        wait_dispatched(dec_count + 20, 1000);

        // keep a few entries waiting so that a frozen dispatch has work to hold
        rob_full = 1'b1;
        wait_queue_level(4, 500);
        mc_wait = 1'b1;
        wait_fetch_idle(100);
        expect_quiet(20, 1'b0);
        {rdy, mc_wait, rob_full} = 3'b000;
        expect_quiet(20, 1'b1);
        rdy = 1'b1;
        wait_dispatched(dec_count + 10, 500);

        if (seen_jal == 0 || seen_taken == 0 || seen_fall == 0) begin
            check_failed("a jump or branch case was never dispatched");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: sources.f
common/frontend_pkg.sv
common/iq_if.sv
fetch/branch_predictor.sv
fetch/fetch_unit.sv
verilog/inst_queue.sv
verilog/dispatch_stage.sv
verilog/frontend_top.sv
sim/tb_frontend.sv

// File: verilog/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic clr,
    input  logic rob_full,
    input  logic slb_full,
    input  logic rs_full,
    iq_if.consumer q,
    output logic dec_en,
    output logic [31:0] dec_inst,
    output logic [frontend_pkg::xlen-1:0] dec_pc,
    output logic dec_pd
);

    logic stall;
    logic do_pop;

    // any full back-end structure holds dispatch
    assign stall = rob_full || slb_full || rs_full;
    assign do_pop = rdy && !clr && !stall && !q.empty;

    assign q.pop = do_pop;

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            dec_en <= 1'b0;
            dec_inst <= '0;
            dec_pc <= '0;
            dec_pd <= 1'b0;
        end else if (rdy) begin
            dec_en <= do_pop;
            if (do_pop) begin
                dec_inst <= q.pop_entry.inst;
                dec_pc <= q.pop_entry.pc;
                dec_pd <= q.pop_entry.pred;
            end else begin
                // idle, show a not-taken bubble
                dec_inst <= '0;
                dec_pc <= '0;
                dec_pd <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic clk,
    input  logic rst,
    input  logic rdy,

    // instruction cache
    output logic ic_en,
    output logic [frontend_pkg::xlen-1:0] ic_pc,
    input  logic ic_done,
    input  logic [31:0] ic_inst,

    // memory controller
    input  logic mc_wait,

    // reorder buffer
    input  logic clr,
    input  logic [frontend_pkg::xlen-1:0] j_pc,
    input  logic bp_upd_en,
    input  logic [frontend_pkg::xlen-1:0] bp_upd_pc,
    input  logic bp_upd_taken,

    // back-end stall levels
    input  logic rob_full,
    input  logic slb_full,
    input  logic rs_full,

    // decoder
    output logic dec_en,
    output logic [31:0] dec_inst,
    output logic [frontend_pkg::xlen-1:0] dec_pc,
    output logic dec_pd
);

    logic [frontend_pkg::xlen-1:0] bp_pc;
    logic bp_taken;

    iq_if u_iq_if (
        .clk(clk)
    );

    fetch_unit u_fetch_unit (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .clr(clr),
        .j_pc(j_pc),
        .mc_wait(mc_wait),
        .ic_done(ic_done),
        .ic_inst(ic_inst),
        .ic_en(ic_en),
        .ic_pc(ic_pc),
        .bp_pc(bp_pc),
        .bp_taken(bp_taken),
        .q(u_iq_if.producer)
    );

    branch_predictor u_branch_predictor (
        .clk(clk),
        .rst(rst),
        .lookup_pc(bp_pc),
        .taken(bp_taken),
        .upd_en(bp_upd_en),
        .upd_pc(bp_upd_pc),
        .upd_taken(bp_upd_taken)
    );

    inst_queue #(
        .entry_t(frontend_pkg::fetch_entry_t)
    ) u_inst_queue (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .q(u_iq_if.buffer)
    );

    dispatch_stage u_dispatch_stage (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .clr(clr),
        .rob_full(rob_full),
        .slb_full(slb_full),
        .rs_full(rs_full),
        .q(u_iq_if.consumer),
        .dec_en(dec_en),
        .dec_inst(dec_inst),
        .dec_pc(dec_pc),
        .dec_pd(dec_pd)
    );

endmodule

// File: verilog/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter type entry_t = frontend_pkg::fetch_entry_t
) (
    input logic clk,
    input logic rst,
    input logic rdy,
    iq_if.buffer q
);
    import frontend_pkg::*;

    entry_t mem [iq_depth];
    logic [iq_ptr_w-1:0] wr_ptr;
    logic [iq_ptr_w-1:0] rd_ptr;
    logic [iq_ptr_w-1:0] wr_nx_ptr;
    logic [iq_ptr_w-1:0] rd_nx_ptr;
    logic [iq_depth-1:0] occupied;
    logic do_push;
    logic do_pop;

    assign wr_nx_ptr = (wr_ptr == iq_ptr_w'(iq_depth - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_nx_ptr = (rd_ptr == iq_ptr_w'(iq_depth - 1)) ? '0 : rd_ptr + 1'b1;

    // one bit per slot
    assign q.full = &occupied;
    assign q.empty = ~|occupied;

    assign do_push = rdy && !q.flush && q.push && !q.full;
    assign do_pop = rdy && !q.flush && q.pop && !q.empty;

    // head entry, no read latency
    assign q.pop_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || q.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occupied <= '0;
        end else begin
            // push and pop never hit the same slot
            if (do_push) begin
                wr_ptr <= wr_nx_ptr;
                occupied[wr_ptr] <= 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_nx_ptr;
                occupied[rd_ptr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= q.push_entry;
        end
    end

endmodule
